// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_pipelined_cache
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
src/cache_pkg.sv
src/cache_control.sv
src/way_store.sv
src/plru_unit.sv
src/hit_check.sv
src/request_path.sv
src/pipelined_cache.sv
tb/line_memory.sv
tb/tb_pipelined_cache.sv

// File: src/cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_req,
    input  logic                    req_read,
    input  logic                    req_write,
    input  logic                    hit,
    input  logic                    victim_dirty,
    input  logic                    dfp_resp,
    output logic                    accept,
    output logic                    replay,
    output cache_pkg::array_write_t array_write,
    output logic                    plru_touch,
    output logic                    ufp_resp,
    output logic                    dfp_read,
    output logic                    dfp_write
);
    import cache_pkg::*;

    cache_state_t state;
    cache_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        accept      = 1'b0;
        replay      = 1'b1;
        array_write = wr_none;
        plru_touch  = 1'b0;
        ufp_resp    = 1'b0;
        dfp_read    = 1'b0;
        dfp_write   = 1'b0;
        case (state)
            st_idle: begin
                replay = 1'b0;
                accept = new_req;
                if (new_req) begin
                    state_next = st_compare;
                end
            end
            st_compare: begin
                if (!hit) begin
                    // dirty victim goes out before the fetch
                    state_next = victim_dirty ? st_writeback : st_fetch;
                end else if (req_write) begin
                    array_write = wr_cpu;
                    plru_touch  = 1'b1;
                    state_next  = st_write_ack;
                end else if (req_read) begin
                    ufp_resp   = 1'b1;
                    plru_touch = 1'b1;
                    replay     = 1'b0;
                    accept     = new_req;
                    state_next = new_req ? st_compare : st_idle;
                end
            end
            st_write_ack: begin
                ufp_resp   = 1'b1;
                replay     = 1'b0;
                accept     = new_req;
                state_next = new_req ? st_compare : st_idle;
            end
            st_writeback: begin
                dfp_write = 1'b1;
                if (dfp_resp) begin
                    state_next = st_fetch;
                end
            end
            st_fetch: begin
                dfp_read = 1'b1;
                if (dfp_resp) begin
                    array_write = wr_fill;
                    state_next  = st_replay;
                end
            end
            // arrays still show pre-fill contents here
            st_replay: state_next = st_compare;
            default:   state_next = st_idle;
        endcase
    end

endmodule

// File: src/cache_pkg.sv
package cache_pkg;

    // geometry
    localparam int num_ways       = 4;
    localparam int num_sets       = 16;
    localparam int words_per_line = 8;

    // address fields: tag 31..9, set 8..5, word 4..2
    typedef logic [31:0]                       addr_t;
    typedef logic [22:0]                       tag_t;
    typedef logic [$clog2(num_sets)-1:0]       set_t;
    typedef logic [$clog2(words_per_line)-1:0] word_sel_t;

    // data widths
    typedef logic [31:0]                   word_t;
    typedef logic [3:0]                    byte_mask_t;
    typedef logic [words_per_line*32-1:0]  line_t;
    typedef logic [words_per_line*4-1:0]   line_mask_t;

    // way bookkeeping
    typedef logic [$clog2(num_ways)-1:0] way_t;
    typedef logic [num_ways-1:0]         way_vec_t;
    typedef logic [num_ways-2:0]         plru_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_write_ack,
        st_writeback,
        st_fetch,
        st_replay
    } cache_state_t;

    typedef enum logic [1:0] {
        wr_none,
        wr_cpu,
        wr_fill
    } array_write_t;

endpackage

// File: src/hit_check.sv
`timescale 1ns/1ps

module hit_check (
    input  cache_pkg::tag_t      req_tag,
    input  cache_pkg::word_sel_t req_word,
    input  cache_pkg::way_t      victim,
    input  cache_pkg::line_t     lines [cache_pkg::num_ways],
    input  cache_pkg::tag_t      tags [cache_pkg::num_ways],
    input  cache_pkg::way_vec_t  valids,
    input  cache_pkg::way_vec_t  dirtys,
    output logic                 hit,
    output cache_pkg::way_t      way_hit,
    output logic                 victim_dirty,
    output cache_pkg::tag_t      victim_tag,
    output cache_pkg::line_t     victim_line,
    output cache_pkg::word_t     rdata
);
    import cache_pkg::*;

    way_vec_t match;

    always_comb begin
        way_hit = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            match[w] = valids[w] && (tags[w] == req_tag);
            // lowest matching way ends up last
            if (match[w]) begin
                way_hit = way_t'(w);
            end
        end
    end

    assign hit   = |match;
    assign rdata = lines[way_hit][{req_word, 5'b0} +: 32];

    // victim details for write-back and fill
    assign victim_dirty = valids[victim] & dirtys[victim];
    assign victim_tag   = tags[victim];
    assign victim_line  = lines[victim];

endmodule

// File: src/pipelined_cache.sv
`timescale 1ns/1ps

module pipelined_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::addr_t      ufp_addr,
    input  cache_pkg::byte_mask_t ufp_rmask,
    input  cache_pkg::byte_mask_t ufp_wmask,
    input  cache_pkg::word_t      ufp_wdata,
    output cache_pkg::word_t      ufp_rdata,
    output logic                  ufp_resp,
    output cache_pkg::addr_t      dfp_addr,
    output logic                  dfp_read,
    output logic                  dfp_write,
    input  cache_pkg::line_t      dfp_rdata,
    output cache_pkg::line_t      dfp_wdata,
    input  logic                  dfp_resp
);
    import cache_pkg::*;

    logic         accept;
    logic         replay;
    array_write_t array_write;
    logic         plru_touch;
    logic         new_req;
    logic         req_read;
    logic         req_write;

    set_t         read_set;
    tag_t         req_tag;
    word_sel_t    req_word;
    way_t         write_way;
    set_t         write_set;
    tag_t         write_tag;
    line_t        write_line;
    line_mask_t   write_mask;
    logic         write_dirty;

    // array outputs, one cycle after read_set
    line_t        lines [num_ways];
    tag_t         tags [num_ways];
    way_vec_t     valids;
    way_vec_t     dirtys;

    logic         hit;
    way_t         way_hit;
    way_t         victim;
    logic         victim_dirty;
    tag_t         victim_tag;
    line_t        victim_line;

    cache_control control_i (
        .clk(clk), .rst(rst), .new_req(new_req), .req_read(req_read),
        .req_write(req_write), .hit(hit), .victim_dirty(victim_dirty),
        .dfp_resp(dfp_resp), .accept(accept), .replay(replay),
        .array_write(array_write), .plru_touch(plru_touch), .ufp_resp(ufp_resp),
        .dfp_read(dfp_read), .dfp_write(dfp_write)
    );

    request_path request_i (
        .clk(clk), .rst(rst), .ufp_addr(ufp_addr), .ufp_rmask(ufp_rmask),
        .ufp_wmask(ufp_wmask), .ufp_wdata(ufp_wdata), .accept(accept),
        .replay(replay), .array_write(array_write), .way_hit(way_hit),
        .victim(victim), .victim_tag(victim_tag), .victim_line(victim_line),
        .dfp_rdata(dfp_rdata), .dfp_write(dfp_write), .new_req(new_req),
        .req_read(req_read), .req_write(req_write), .read_set(read_set),
        .req_tag(req_tag), .req_word(req_word), .write_way(write_way),
        .write_set(write_set), .write_tag(write_tag), .write_line(write_line),
        .write_mask(write_mask), .write_dirty(write_dirty), .dfp_addr(dfp_addr),
        .dfp_wdata(dfp_wdata)
    );

    way_store store_i (
        .clk(clk), .rst(rst), .read_set(read_set), .write_en(array_write),
        .write_way(write_way), .write_set(write_set), .write_tag(write_tag),
        .write_line(write_line), .write_mask(write_mask), .write_dirty(write_dirty),
        .lines(lines), .tags(tags), .valids(valids), .dirtys(dirtys)
    );

    hit_check hit_i (
        .req_tag(req_tag), .req_word(req_word), .victim(victim), .lines(lines),
        .tags(tags), .valids(valids), .dirtys(dirtys), .hit(hit), .way_hit(way_hit),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .victim_line(victim_line), .rdata(ufp_rdata)
    );

    // tree bits follow the stage 1 set
    plru_unit plru_i (
        .clk(clk), .rst(rst), .set(write_set), .touch(plru_touch),
        .way_hit(way_hit), .valids(valids), .victim(victim)
    );

endmodule

// File: src/plru_unit.sv
`timescale 1ns/1ps

module plru_unit (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_t     set,
    input  logic                touch,
    input  cache_pkg::way_t     way_hit,
    input  cache_pkg::way_vec_t valids,
    output cache_pkg::way_t     victim
);
    import cache_pkg::*;

    // bit 0 picks the half, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    plru_t tree [num_sets];
    plru_t bits;
    way_t  tree_way;

    assign bits     = tree[set];
    assign tree_way = bits[0] ? {1'b1, bits[2]} : {1'b0, bits[1]};

    // an empty way wins over the tree choice
    always_comb begin
        victim = tree_way;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valids[w]) begin
                victim = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tree <= '{default: '0};
        end else if (touch) begin
            tree[set][0] <= ~way_hit[1];
            if (way_hit[1]) begin
                tree[set][2] <= ~way_hit[0];
            end else begin
                tree[set][1] <= ~way_hit[0];
            end
        end
    end

endmodule

// File: src/request_path.sv
`timescale 1ns/1ps

module request_path (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::addr_t        ufp_addr,
    input  cache_pkg::byte_mask_t   ufp_rmask,
    input  cache_pkg::byte_mask_t   ufp_wmask,
    input  cache_pkg::word_t        ufp_wdata,
    input  logic                    accept,
    input  logic                    replay,
    input  cache_pkg::array_write_t array_write,
    input  cache_pkg::way_t         way_hit,
    input  cache_pkg::way_t         victim,
    input  cache_pkg::tag_t         victim_tag,
    input  cache_pkg::line_t        victim_line,
    input  cache_pkg::line_t        dfp_rdata,
    input  logic                    dfp_write,
    output logic                    new_req,
    output logic                    req_read,
    output logic                    req_write,
    output cache_pkg::set_t         read_set,
    output cache_pkg::tag_t         req_tag,
    output cache_pkg::word_sel_t    req_word,
    output cache_pkg::way_t         write_way,
    output cache_pkg::set_t         write_set,
    output cache_pkg::tag_t         write_tag,
    output cache_pkg::line_t        write_line,
    output cache_pkg::line_mask_t   write_mask,
    output logic                    write_dirty,
    output cache_pkg::addr_t        dfp_addr,
    output cache_pkg::line_t        dfp_wdata
);
    import cache_pkg::*;

    // stage 1 request
    addr_t      req_addr;
    byte_mask_t req_rmask;
    byte_mask_t req_wmask;
    word_t      req_wdata;
    set_t       req_set;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_rmask <= '0;
            req_wmask <= '0;
        end else if (accept) begin
            req_rmask <= ufp_rmask;
            req_wmask <= ufp_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= ufp_addr;
            req_wdata <= ufp_wdata;
        end
    end

    assign new_req   = (|ufp_rmask) | (|ufp_wmask);
    assign req_read  = |req_rmask;
    assign req_write = |req_wmask;
    assign req_tag   = req_addr[31:9];
    assign req_set   = req_addr[8:5];
    assign req_word  = req_addr[4:2];

    // replay keeps the arrays pointed at the pending request
    assign read_set  = replay ? req_set : ufp_addr[8:5];
    assign write_set = req_set;
    assign write_tag = req_tag;

    always_comb begin
        write_way   = way_hit;
        write_line  = dfp_rdata;
        write_mask  = '0;
        write_dirty = 1'b0;
        case (array_write)
            wr_cpu: begin
                write_line  = line_t'(req_wdata) << {req_word, 5'b0};
                write_mask  = line_mask_t'(req_wmask) << {req_word, 2'b0};
                write_dirty = 1'b1;
            end
            wr_fill: begin
                write_way  = victim;
                write_mask = '1;
            end
            default: ;
        endcase
    end

    // memory side, always a whole line
    assign dfp_addr  = {(dfp_write ? victim_tag : req_tag), req_set, 5'b0};
    assign dfp_wdata = victim_line;

endmodule

// File: src/way_store.sv
`timescale 1ns/1ps

module way_store (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::set_t         read_set,
    input  cache_pkg::array_write_t write_en,
    input  cache_pkg::way_t         write_way,
    input  cache_pkg::set_t         write_set,
    input  cache_pkg::tag_t         write_tag,
    input  cache_pkg::line_t        write_line,
    input  cache_pkg::line_mask_t   write_mask,
    input  logic                    write_dirty,
    output cache_pkg::line_t        lines [cache_pkg::num_ways],
    output cache_pkg::tag_t         tags [cache_pkg::num_ways],
    output cache_pkg::way_vec_t     valids,
    output cache_pkg::way_vec_t     dirtys
);
    import cache_pkg::*;

    line_t    data_mem [num_ways][num_sets];
    tag_t     tag_mem [num_ways][num_sets];
    way_vec_t valid_bits [num_sets];
    way_vec_t dirty_bits [num_sets];

    // line and tag storage, read is registered
    always_ff @(posedge clk) begin
        if (write_en != wr_none) begin
            for (int b = 0; b < words_per_line * 4; b++) begin
                if (write_mask[b]) begin
                    data_mem[write_way][write_set][8*b +: 8] <= write_line[8*b +: 8];
                end
            end
            tag_mem[write_way][write_set] <= write_tag;
        end
        for (int w = 0; w < num_ways; w++) begin
            lines[w] <= data_mem[w][read_set];
            tags[w]  <= tag_mem[w][read_set];
        end
    end

    // status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '{default: '0};
            dirty_bits <= '{default: '0};
            valids     <= '0;
            dirtys     <= '0;
        end else begin
            if (write_en != wr_none) begin
                valid_bits[write_set][write_way] <= 1'b1;
                dirty_bits[write_set][write_way] <= write_dirty;
            end
            valids <= valid_bits[read_set];
            dirtys <= dirty_bits[read_set];
        end
    end

endmodule

// File: tb/line_memory.sv
`timescale 1ns/1ps

module line_memory (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t dfp_addr,
    input  logic             dfp_read,
    input  logic             dfp_write,
    input  cache_pkg::line_t dfp_wdata,
    output cache_pkg::line_t dfp_rdata,
    output logic             dfp_resp
);
    import cache_pkg::*;

    // written-back lines, keyed by line address
    line_t lines [addr_t];
    logic  busy;
    int    wait_left;

    // contents of a line never written, mixes every address bit
    function automatic word_t init_word(addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    function automatic line_t read_line(addr_t base);
        line_t l;
        if (lines.exists(base)) begin
            return lines[base];
        end
        for (int i = 0; i < words_per_line; i++) begin
            l[32*i +: 32] = init_word(base + addr_t'(4 * i));
        end
        return l;
    endfunction

    // one request at a time, answered 1 to 4 cycles after it shows up
    initial begin
        busy      = 1'b0;
        wait_left = 0;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            dfp_resp = 1'b0;
            if (!rst && (dfp_read || dfp_write)) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $urandom_range(0, 3);
                end
                if (wait_left == 0) begin
                    if (dfp_write) begin
                        lines[dfp_addr] = dfp_wdata;
                    end else begin
                        dfp_rdata = read_line(dfp_addr);
                    end
                    dfp_resp = 1'b1;
                    busy     = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

endmodule

// File: tb/tb_pipelined_cache.sv
`timescale 1ns/1ps

module tb_pipelined_cache;
    import cache_pkg::*;

    localparam int clk_period         = 10;
    localparam int num_requests       = 2000;
    localparam int cycles_per_request = 40;

    logic        clk;
    logic        rst;
    addr_t       ufp_addr;
    byte_mask_t  ufp_rmask;
    byte_mask_t  ufp_wmask;
    word_t       ufp_wdata;
    word_t       ufp_rdata;
    logic        ufp_resp;
    addr_t       dfp_addr;
    logic        dfp_read;
    logic        dfp_write;
    line_t       dfp_rdata;
    line_t       dfp_wdata;
    logic        dfp_resp;

    // reference memory from word address to data
    word_t       model_mem [addr_t];
    tag_t        tag_pool [6];
    set_t        set_pool [2];
    addr_t       cur_addr;
    logic        monitor_on;
    logic        dfp_seen;

    pipelined_cache dut_i (
        .clk(clk), .rst(rst), .ufp_addr(ufp_addr), .ufp_rmask(ufp_rmask),
        .ufp_wmask(ufp_wmask), .ufp_wdata(ufp_wdata), .ufp_rdata(ufp_rdata),
        .ufp_resp(ufp_resp), .dfp_addr(dfp_addr), .dfp_read(dfp_read),
        .dfp_write(dfp_write), .dfp_rdata(dfp_rdata), .dfp_wdata(dfp_wdata),
        .dfp_resp(dfp_resp)
    );

    line_memory mem_i (
        .clk(clk), .rst(rst), .dfp_addr(dfp_addr), .dfp_read(dfp_read),
        .dfp_write(dfp_write), .dfp_wdata(dfp_wdata), .dfp_rdata(dfp_rdata),
        .dfp_resp(dfp_resp)
    );

    always #(clk_period / 2) clk = ~clk;

    // same fill rule as the line memory
    function automatic word_t init_word(addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    function automatic word_t model_read(addr_t a);
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return init_word(a);
    endfunction

    task automatic model_write(input addr_t a, input word_t data, input byte_mask_t mask);
        word_t w;
        w = model_read(a);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        model_mem[a] = w;
    endtask

    task automatic fail_run();
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    // drive one request, wait for its response and check it
    task automatic issue_request(input addr_t a, input byte_mask_t rmask,
                                 input byte_mask_t wmask, input word_t wdata,
                                 output int cycles);
        cur_addr  = a;
        dfp_seen  = 1'b0;
        ufp_addr  = a;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        @(posedge clk);
        #1;
        cycles = 1;
        while (!ufp_resp) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (rmask != 0) begin
            check_word("ufp_rdata", ufp_rdata, model_read(a));
        end
        if (wmask != 0) begin
            model_write(a, wdata, wmask);
        end
    endtask

    task automatic check_quiet_outputs();
        check_flag("ufp_resp", ufp_resp, 1'b0);
        check_flag("dfp_read", dfp_read, 1'b0);
        check_flag("dfp_write", dfp_write, 1'b0);
    endtask

    // memory side protocol
    always @(negedge clk) begin
        if (monitor_on && (dfp_read || dfp_write)) begin
            dfp_seen = 1'b1;
            check_flag("dfp_read & dfp_write", dfp_read & dfp_write, 1'b0);
            if (dfp_read) begin
                check_addr("dfp_addr", dfp_addr, {cur_addr[31:5], 5'b0});
            end else begin
                // victim sits in the request's set and holds what the CPU wrote
                check_addr("dfp_addr[8:0]", addr_t'(dfp_addr[8:0]),
                           addr_t'({cur_addr[8:5], 5'b0}));
                for (int i = 0; i < words_per_line; i++) begin
                    check_word("dfp_wdata", dfp_wdata[32*i +: 32],
                               model_read(dfp_addr + addr_t'(4 * i)));
                end
            end
        end
    end

    initial begin
        #(num_requests * cycles_per_request * clk_period);
        $display("timeout: run did not finish in %0d cycles", num_requests * cycles_per_request);
        fail_run();
    end

    initial begin
        addr_t      addr;
        byte_mask_t rmask;
        byte_mask_t wmask;
        word_t      wdata;
        int         latency;
        int         tag_idx;
        int         set_idx;
        logic       repeat_read;
        logic       last_read;
        logic       back_to_back;

        void'($urandom(62995));
        clk        = 1'b0;
        rst        = 1'b1;
        ufp_addr   = '0;
        ufp_rmask  = '0;
        ufp_wmask  = '0;
        ufp_wdata  = '0;
        cur_addr   = '0;
        monitor_on = 1'b0;
        dfp_seen   = 1'b0;
        // 6 tags over 2 sets keeps the 4 ways under pressure
        for (int t = 0; t < 6; t++) begin
            tag_pool[t] = tag_t'(32'h1c0 + t * 32'h2b5);
        end
        set_pool[0] = 4'd3;
        set_pool[1] = 4'd12;

        repeat (5) begin
            @(posedge clk);
            #1;
            check_quiet_outputs();
        end
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_quiet_outputs();
        end
        monitor_on = 1'b1;

        last_read    = 1'b0;
        back_to_back = 1'b0;
        addr         = '0;
        for (int i = 0; i < num_requests; i++) begin
            repeat_read = back_to_back && last_read && ($urandom_range(0, 3) == 0);
            if (repeat_read) begin
                rmask = 4'hf;
                wmask = '0;
            end else begin
                tag_idx = $urandom_range(0, 5);
                set_idx = $urandom_range(0, 1);
                addr    = {tag_pool[tag_idx], set_pool[set_idx],
                           word_sel_t'($urandom_range(0, 7)), 2'b00};
                if ($urandom_range(0, 1) == 1) begin
                    rmask = byte_mask_t'($urandom_range(1, 15));
                    wmask = '0;
                end else begin
                    rmask = '0;
                    wmask = byte_mask_t'($urandom_range(1, 15));
                end
            end
            wdata = $urandom();
            issue_request(addr, rmask, wmask, wdata, latency);
            if (repeat_read) begin
                check_flag("back-to-back read hit in one cycle", latency == 1, 1'b1);
                check_flag("dfp activity on back-to-back read", dfp_seen, 1'b0);
            end
            last_read    = (rmask != 0);
            back_to_back = ($urandom_range(0, 1) == 1);
            if (!back_to_back) begin
                ufp_rmask = '0;
                ufp_wmask = '0;
                repeat ($urandom_range(1, 2)) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        ufp_rmask = '0;
        ufp_wmask = '0;
        repeat (4) begin
            @(posedge clk);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
